//--- afu_pkg.sv
// ==============================
// Accelerator shared definitions
// ==============================

package afu_pkg;

    // Data word for MMIO, host memory and checksum
    typedef logic [63:0] word_t;

    // CSR word index, one 64 bit word per index
    typedef logic [3:0] csr_idx_t;

    // Word counts and completion counters
    typedef logic [31:0] count_t;

    // CSR map
    localparam csr_idx_t CSR_ID_LO    = 4'd0;
    localparam csr_idx_t CSR_ID_HI    = 4'd1;
    localparam csr_idx_t CSR_CONFIG   = 4'd2;
    localparam csr_idx_t CSR_CTRL     = 4'd3;
    localparam csr_idx_t CSR_BASE     = 4'd4;
    localparam csr_idx_t CSR_LEN      = 4'd5;
    localparam csr_idx_t CSR_SEED     = 4'd6;
    localparam csr_idx_t CSR_STATUS   = 4'd7;
    localparam csr_idx_t CSR_CHECKSUM = 4'd8;
    localparam csr_idx_t CSR_RD_COUNT = 4'd9;
    localparam csr_idx_t CSR_WR_COUNT = 4'd10;

    // Run mode, bit 0 selects writes and bit 1 selects reads
    typedef enum logic [1:0] {
        MODE_IDLE       = 2'd0,
        MODE_WRITE      = 2'd1,
        MODE_READ       = 2'd2,
        MODE_WRITE_READ = 2'd3
    } eng_mode_t;

    // Engine FSM, a REQ/DROP pair per transfer direction
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WR_REQ,
        ST_WR_DROP,
        ST_RD_REQ,
        ST_RD_DROP,
        ST_DONE
    } eng_state_t;

    // Test ID reported through CSR_ID_LO and CSR_ID_HI
    localparam logic [127:0] AFU_TEST_ID = 128'h7a3e91d2_5c08_4f6b_b2d4_1e9c60a8f357;

    localparam int NUM_ENGINES = 1;

endpackage

//--- afu_csr_decode.sv
// ==============================
// MMIO CSR decode
// ==============================

`timescale 1ns/1ps

module afu_csr_decode
#(
    parameter logic [7:0] AFU_INSTANCE_ID = 8'd0,
    parameter int         MEM_ADDR_WIDTH  = 20
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mmio_write,
    input  logic                      mmio_read,
    input  afu_pkg::csr_idx_t         mmio_address,
    input  afu_pkg::word_t            mmio_writedata,
    input  logic                      busy,
    input  logic                      done,
    input  afu_pkg::word_t            checksum,
    input  afu_pkg::count_t           rd_count,
    input  afu_pkg::count_t           wr_count,
    output logic                      mmio_readdatavalid,
    output afu_pkg::word_t            mmio_readdata,
    output logic                      start,
    output afu_pkg::eng_mode_t        mode,
    output logic [MEM_ADDR_WIDTH-1:0] base,
    output afu_pkg::count_t           len,
    output afu_pkg::word_t            seed
);
    import afu_pkg::*;

    // Read mux output before the response register
    word_t rd_mux;

    // ==============================
    // Write decode
    // ==============================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            start <= 1'b0;
            mode  <= MODE_IDLE;
            base  <= '0;
            len   <= '0;
            seed  <= '0;
        end
        else
        begin
            // Start is a single cycle pulse
            start <= 1'b0;
            if (mmio_write)
            begin
                case (mmio_address)
                    CSR_CTRL:
                    begin
                        start <= mmio_writedata[0];
                        mode  <= eng_mode_t'(mmio_writedata[2:1]);
                    end
                    CSR_BASE: base <= mmio_writedata[MEM_ADDR_WIDTH-1:0];
                    CSR_LEN:  len  <= mmio_writedata[31:0];
                    CSR_SEED: seed <= mmio_writedata;
                    default:  ;
                endcase
            end
        end
    end

    // ==============================
    // Read path
    // ==============================

    always_comb
    begin
        case (mmio_address)
            CSR_ID_LO:    rd_mux = AFU_TEST_ID[63:0];
            CSR_ID_HI:    rd_mux = AFU_TEST_ID[127:64];
            // Instance in 15:8, engine count in 7:0
            CSR_CONFIG:   rd_mux = {48'd0, AFU_INSTANCE_ID, 8'(NUM_ENGINES)};
            CSR_CTRL:     rd_mux = {61'd0, mode, 1'b0};
            CSR_BASE:     rd_mux = word_t'(base);
            CSR_LEN:      rd_mux = word_t'(len);
            CSR_SEED:     rd_mux = seed;
            CSR_STATUS:   rd_mux = {62'd0, done, busy};
            CSR_CHECKSUM: rd_mux = checksum;
            CSR_RD_COUNT: rd_mux = word_t'(rd_count);
            CSR_WR_COUNT: rd_mux = word_t'(wr_count);
            default:      rd_mux = '0;
        endcase
    end

    // One cycle read latency
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mmio_readdatavalid <= 1'b0;
        end
        else
        begin
            mmio_readdatavalid <= mmio_read;
        end
    end

    // Data only matters with the valid flag
    always_ff @(posedge clk)
    begin
        if (mmio_read)
        begin
            mmio_readdata <= rd_mux;
        end
    end

    // Host never issues read and write together
    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst)
        !(mmio_read && mmio_write))
        else $error("MMIO read and write in the same cycle");

endmodule

//--- afu_rdwr_engine.sv
// ==============================
// Host memory read/write engine
// ==============================

`timescale 1ns/1ps

module afu_rdwr_engine
#(
    parameter int MEM_ADDR_WIDTH = 20
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  afu_pkg::eng_mode_t        mode,
    input  logic [MEM_ADDR_WIDTH-1:0] base,
    input  afu_pkg::count_t           len,
    input  afu_pkg::word_t            seed,
    input  logic                      mem_ack,
    input  afu_pkg::word_t            mem_rdata,
    output logic                      mem_req,
    output logic                      mem_we,
    output logic [MEM_ADDR_WIDTH-1:0] mem_addr,
    output afu_pkg::word_t            mem_wdata,
    output logic                      run_start,
    output logic                      run_end,
    output logic                      wr_done,
    output logic                      rd_done,
    output afu_pkg::word_t            rd_data
);
    import afu_pkg::*;

    localparam logic [MEM_ADDR_WIDTH-1:0] ADDR_ONE = {{(MEM_ADDR_WIDTH-1){1'b0}}, 1'b1};

    eng_state_t                state;
    // Settings latched at run start
    eng_mode_t                 run_mode;
    logic [MEM_ADDR_WIDTH-1:0] run_base;
    count_t                    run_len;
    // Transfers acknowledged in the current pass
    count_t                    xfer_cnt;
    logic                      run_has_rd;
    logic                      last_xfer;

    assign run_has_rd = (run_mode == MODE_READ) || (run_mode == MODE_WRITE_READ);
    assign last_xfer  = (xfer_cnt == run_len);

    // Status strobes
    // Start only counts when idle
    assign run_start = start && (state == ST_IDLE);
    // ST_DONE lasts one cycle
    assign run_end   = (state == ST_DONE);
    assign wr_done   = (state == ST_WR_REQ) && mem_ack;
    assign rd_done   = (state == ST_RD_REQ) && mem_ack;
    // Read data is valid while ack is high
    assign rd_data   = mem_rdata;

    // ==============================
    // Transfer FSM
    // ==============================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= ST_IDLE;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (start)
                    begin
                        run_mode  <= mode;
                        run_base  <= base;
                        run_len   <= len;
                        xfer_cnt  <= '0;
                        mem_addr  <= base;
                        mem_wdata <= seed;
                        // Empty run finishes at once
                        if ((len == '0) || (mode == MODE_IDLE))
                        begin
                            state <= ST_DONE;
                        end
                        else if (mode == MODE_READ)
                        begin
                            mem_req <= 1'b1;
                            mem_we  <= 1'b0;
                            state   <= ST_RD_REQ;
                        end
                        else
                        begin
                            mem_req <= 1'b1;
                            mem_we  <= 1'b1;
                            state   <= ST_WR_REQ;
                        end
                    end
                end
                ST_WR_REQ:
                begin
                    // Hold request until memory acks
                    if (mem_ack)
                    begin
                        mem_req  <= 1'b0;
                        xfer_cnt <= xfer_cnt + 32'd1;
                        state    <= ST_WR_DROP;
                    end
                end
                ST_WR_DROP:
                begin
                    // Next request only after ack falls
                    if (!mem_ack)
                    begin
                        if (!last_xfer)
                        begin
                            mem_addr  <= mem_addr + ADDR_ONE;
                            mem_wdata <= mem_wdata + 64'd1;
                            mem_req   <= 1'b1;
                            state     <= ST_WR_REQ;
                        end
                        else if (run_has_rd)
                        begin
                            // Read back from the start of the region
                            xfer_cnt <= '0;
                            mem_addr <= run_base;
                            mem_we   <= 1'b0;
                            mem_req  <= 1'b1;
                            state    <= ST_RD_REQ;
                        end
                        else
                        begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_RD_REQ:
                begin
                    if (mem_ack)
                    begin
                        mem_req  <= 1'b0;
                        xfer_cnt <= xfer_cnt + 32'd1;
                        state    <= ST_RD_DROP;
                    end
                end
                ST_RD_DROP:
                begin
                    if (!mem_ack)
                    begin
                        if (!last_xfer)
                        begin
                            mem_addr <= mem_addr + ADDR_ONE;
                            mem_req  <= 1'b1;
                            state    <= ST_RD_REQ;
                        end
                        else
                        begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request is never withdrawn before ack
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req)
        else $error("mem_req dropped before mem_ack");

    // Request fields frozen for the whole handshake
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && $past(mem_req) |->
            $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata))
        else $error("Request fields changed while mem_req high");

endmodule

//--- afu_eng_status.sv
// ==============================
// Engine status and counters
// ==============================

`timescale 1ns/1ps

module afu_eng_status
(
    input  logic            clk,
    input  logic            rst,
    input  logic            run_start,
    input  logic            run_end,
    input  logic            wr_done,
    input  logic            rd_done,
    input  afu_pkg::word_t  rd_data,
    output logic            busy,
    output logic            done,
    output afu_pkg::word_t  checksum,
    output afu_pkg::count_t rd_count,
    output afu_pkg::count_t wr_count
);

    // ==============================
    // Run flags
    // ==============================

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            done <= 1'b0;
        end
        else if (run_start)
        begin
            busy <= 1'b1;
            done <= 1'b0;
        end
        else if (run_end)
        begin
            // Done rises as busy falls
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

    // ==============================
    // Checksum and counters
    // ==============================

    always_ff @(posedge clk)
    begin
        if (rst || run_start)
        begin
            checksum <= '0;
            rd_count <= '0;
            wr_count <= '0;
        end
        else
        begin
            // Wrapping 64 bit sum of read words
            if (rd_done)
            begin
                checksum <= checksum + rd_data;
                rd_count <= rd_count + 32'd1;
            end
            if (wr_done)
            begin
                wr_count <= wr_count + 32'd1;
            end
        end
    end

    // A run always lasts at least one cycle
    a_start_end: assert property (@(posedge clk) disable iff (rst)
        !(run_start && run_end))
        else $error("run_start and run_end in the same cycle");

endmodule

//--- afu_top.sv
// ==============================
// Memory test accelerator top
// ==============================

`timescale 1ns/1ps

module afu_top
#(
    parameter logic [7:0] AFU_INSTANCE_ID = 8'd0,
    parameter int         MEM_ADDR_WIDTH  = 20
)
(
    input  logic                      clk,
    input  logic                      rst,
    // MMIO
    input  logic                      mmio_write,
    input  logic                      mmio_read,
    input  afu_pkg::csr_idx_t         mmio_address,
    input  afu_pkg::word_t            mmio_writedata,
    output logic                      mmio_readdatavalid,
    output afu_pkg::word_t            mmio_readdata,
    // Host memory, four-phase req/ack
    output logic                      mem_req,
    output logic                      mem_we,
    output logic [MEM_ADDR_WIDTH-1:0] mem_addr,
    output afu_pkg::word_t            mem_wdata,
    input  logic                      mem_ack,
    input  afu_pkg::word_t            mem_rdata
);
    import afu_pkg::*;

    // Decode to engine
    logic                      start;
    eng_mode_t                 mode;
    logic [MEM_ADDR_WIDTH-1:0] base;
    count_t                    len;
    word_t                     seed;

    // Engine to status
    logic                      run_start;
    logic                      run_end;
    logic                      wr_done;
    logic                      rd_done;
    word_t                     rd_data;

    // Status to read mux
    logic                      busy;
    logic                      done;
    word_t                     checksum;
    count_t                    rd_count;
    count_t                    wr_count;

    afu_csr_decode
    #(
        .AFU_INSTANCE_ID(AFU_INSTANCE_ID),
        .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
    )
    u_csr_decode
    (
        .clk, .rst,
        .mmio_write, .mmio_read, .mmio_address, .mmio_writedata,
        .busy, .done, .checksum, .rd_count, .wr_count,
        .mmio_readdatavalid, .mmio_readdata,
        .start, .mode, .base, .len, .seed
    );

    afu_rdwr_engine
    #(
        .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
    )
    u_rdwr_engine
    (
        .clk, .rst,
        .start, .mode, .base, .len, .seed,
        .mem_ack, .mem_rdata,
        .mem_req, .mem_we, .mem_addr, .mem_wdata,
        .run_start, .run_end, .wr_done, .rd_done, .rd_data
    );

    afu_eng_status u_eng_status
    (
        .clk, .rst,
        .run_start, .run_end, .wr_done, .rd_done, .rd_data,
        .busy, .done, .checksum, .rd_count, .wr_count
    );

endmodule

//--- tb_clkgen.sv
// ==============================
// Testbench clock and reset
// ==============================

`timescale 1ns/1ps

module tb_clkgen
#(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 2
)
(
    output logic clk,
    output logic rst
);

    // 40 ns period with the default half period
    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Held over the first rising edges, released on a falling edge
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- tb_afu.sv
// ==============================
// Accelerator testbench
// ==============================

`timescale 1ns/1ps

module tb_afu;
    import afu_pkg::*;

    localparam int         MEM_ADDR_WIDTH = 12;
    localparam int         MEM_WORDS      = 1 << MEM_ADDR_WIDTH;
    localparam logic [7:0] INSTANCE_ID    = 8'd5;
    // Longest run is 64 words written then read, under 8 cycles each, plus MMIO and margin
    localparam int         TIMEOUT_CYCLES = 20000;

    typedef logic [MEM_ADDR_WIDTH-1:0] addr_t;

    logic  clk;
    logic  rst;
    // MMIO
    logic     mmio_write;
    logic     mmio_read;
    csr_idx_t mmio_address;
    word_t    mmio_writedata;
    logic     mmio_readdatavalid;
    word_t    mmio_readdata;
    // Host memory
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_ack;
    word_t mem_rdata;

    // Memory model contents and the expected image
    word_t host_mem [MEM_WORDS];
    word_t shadow   [MEM_WORDS];
    // Transfers seen by the monitor, write flag above the address
    logic [MEM_ADDR_WIDTH:0] xfer_q [$];

    int   seed        = 25;
    int   error_count = 0;
    int   check_count = 0;
    int   cycle_count = 0;
    logic prev_req    = 1'b0;
    // Ack as seen on the edge where the engine decided to raise a request
    logic prev_ack    = 1'b0;

    tb_clkgen #(.HALF_PERIOD(20), .RESET_CYCLES(2)) u_clkgen (.clk, .rst);

    afu_top
    #(
        .AFU_INSTANCE_ID(INSTANCE_ID),
        .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
    )
    UUT
    (
        .clk, .rst,
        .mmio_write, .mmio_read, .mmio_address, .mmio_writedata,
        .mmio_readdatavalid, .mmio_readdata,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

    // ==============================
    // Host memory model
    // ==============================

    initial
    begin
        int delay;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever
        begin
            @(negedge clk);
            if (mem_req && !mem_ack)
            begin
                // Back-pressure of 0 to 3 cycles
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(negedge clk);
                if (mem_we)
                begin
                    host_mem[mem_addr] = mem_wdata;
                end
                else
                begin
                    mem_rdata = host_mem[mem_addr];
                end
                mem_ack = 1'b1;
                // Hold ack until the request drops
                while (mem_req) @(negedge clk);
                mem_ack = 1'b0;
            end
        end
    end

    // Handshake monitor, sampled on the rising edge
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (mem_req && !prev_req && prev_ack)
            begin
                $display("Monitor: mem_req rose while mem_ack was still high, cycle %0d",
                         cycle_count);
                error_count++;
            end
            if (mem_req && mem_ack)
            begin
                // A write right after a read breaks write-then-read order
                if (mem_we && (xfer_q.size() > 0))
                begin
                    if (!xfer_q[xfer_q.size()-1][MEM_ADDR_WIDTH])
                    begin
                        $display("Monitor: write to %h issued after a read", mem_addr);
                        error_count++;
                    end
                end
                xfer_q.push_back({mem_we, mem_addr});
            end
        end
        prev_req = mem_req;
        prev_ack = mem_ack;
    end

    // Run limit
    initial
    begin
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // ==============================
    // Reference model and checks
    // ==============================

    // Wrapping 64 bit sum over the expected memory image
    function automatic word_t ref_checksum(input addr_t base_addr, input int count);
        word_t sum;
        addr_t a;
        sum = '0;
        for (int i = 0; i < count; i++)
        begin
            a   = base_addr + addr_t'(i);
            sum = sum + shadow[a];
        end
        return sum;
    endfunction

    // Word i of a write run is seed+i
    task automatic expect_writes(input addr_t base_addr, input int count, input word_t run_seed);
        addr_t a;
        for (int i = 0; i < count; i++)
        begin
            a         = base_addr + addr_t'(i);
            shadow[a] = run_seed + word_t'(i);
        end
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected)
        begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // ==============================
    // MMIO access
    // ==============================

    task automatic mmio_wr(input csr_idx_t idx, input word_t data);
        @(negedge clk);
        mmio_write     = 1'b1;
        mmio_address   = idx;
        mmio_writedata = data;
        @(negedge clk);
        mmio_write     = 1'b0;
    endtask

    task automatic mmio_rd(input csr_idx_t idx, output word_t data);
        @(negedge clk);
        mmio_read    = 1'b1;
        mmio_address = idx;
        @(negedge clk);
        mmio_read    = 1'b0;
        while (!mmio_readdatavalid) @(negedge clk);
        data = mmio_readdata;
    endtask

    task automatic check_csr(input string name, input csr_idx_t idx, input word_t expected);
        word_t data;
        mmio_rd(idx, data);
        compare_word(name, expected, data);
    endtask

    task automatic launch_run(input eng_mode_t run_mode, input addr_t base_addr,
                              input int count, input word_t run_seed);
        xfer_q.delete();
        mmio_wr(CSR_BASE, word_t'(base_addr));
        mmio_wr(CSR_LEN, word_t'(count));
        mmio_wr(CSR_SEED, run_seed);
        mmio_wr(CSR_CTRL, {61'd0, run_mode, 1'b1});
    endtask

    // Poll status until done, then busy must be low
    task automatic wait_done(input string name);
        word_t status;
        status = '0;
        while (!status[1]) mmio_rd(CSR_STATUS, status);
        compare_word({name, " status at end"}, 64'd2, status);
    endtask

    // Addresses in order from base, counts per direction
    task automatic check_transfers(input string name, input addr_t base_addr, input int count,
                                   input bit has_wr, input bit has_rd);
        int                      n_wr;
        int                      n_rd;
        addr_t                   a;
        logic [MEM_ADDR_WIDTH:0] entry;
        n_wr = 0;
        n_rd = 0;
        for (int k = 0; k < xfer_q.size(); k++)
        begin
            entry = xfer_q[k];
            if (entry[MEM_ADDR_WIDTH])
            begin
                a = base_addr + addr_t'(n_wr);
                n_wr++;
            end
            else
            begin
                a = base_addr + addr_t'(n_rd);
                n_rd++;
            end
            compare_word($sformatf("%s transfer %0d address", name, k),
                         word_t'(a), word_t'(entry[MEM_ADDR_WIDTH-1:0]));
        end
        compare_word({name, " write transfers"}, has_wr ? word_t'(count) : 64'd0, word_t'(n_wr));
        compare_word({name, " read transfers"}, has_rd ? word_t'(count) : 64'd0, word_t'(n_rd));
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        word_t data;
        addr_t a;
        mmio_write     = 1'b0;
        mmio_read      = 1'b0;
        mmio_address   = '0;
        mmio_writedata = '0;
        // Fill pattern carries the full address twice
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            host_mem[addr_t'(i)] = {20'hc0ffe, addr_t'(i), 20'h5a5a5, addr_t'(i)};
            shadow[addr_t'(i)]   = {20'hc0ffe, addr_t'(i), 20'h5a5a5, addr_t'(i)};
        end
        @(posedge clk);
        while (rst) @(posedge clk);

        // Reset values and identity
        check_csr("reset status", CSR_STATUS, 64'd0);
        check_csr("reset checksum", CSR_CHECKSUM, 64'd0);
        check_csr("test id low", CSR_ID_LO, AFU_TEST_ID[63:0]);
        check_csr("test id high", CSR_ID_HI, AFU_TEST_ID[127:64]);
        check_csr("config", CSR_CONFIG, {48'd0, INSTANCE_ID, 8'd1});
        check_csr("unused index", 4'd13, 64'd0);

        // Write run
        launch_run(MODE_WRITE, 12'h100, 16, 64'h1234);
        expect_writes(12'h100, 16, 64'h1234);
        wait_done("write run");
        for (int i = 0; i < 16; i++)
        begin
            a = 12'h100 + addr_t'(i);
            compare_word($sformatf("write run mem[%h]", a), shadow[a], host_mem[a]);
        end
        check_csr("write run wr count", CSR_WR_COUNT, 64'd16);
        check_csr("write run rd count", CSR_RD_COUNT, 64'd0);
        check_transfers("write run", 12'h100, 16, 1'b1, 1'b0);

        // Read run over random words
        for (int i = 0; i < 32; i++)
        begin
            a           = 12'h200 + addr_t'(i);
            data        = {$random(seed), $random(seed)};
            host_mem[a] = data;
            shadow[a]   = data;
        end
        launch_run(MODE_READ, 12'h200, 32, 64'd0);
        wait_done("read run");
        check_csr("read run checksum", CSR_CHECKSUM, ref_checksum(12'h200, 32));
        check_csr("read run rd count", CSR_RD_COUNT, 64'd32);
        check_csr("read run wr count", CSR_WR_COUNT, 64'd0);
        check_transfers("read run", 12'h200, 32, 1'b0, 1'b1);

        // Write then read back, data wraps past 2^64
        launch_run(MODE_WRITE_READ, 12'h400, 64, 64'hffff_ffff_ffff_ffe0);
        expect_writes(12'h400, 64, 64'hffff_ffff_ffff_ffe0);
        wait_done("write read run");
        check_csr("write read run checksum", CSR_CHECKSUM, ref_checksum(12'h400, 64));
        check_csr("write read run wr count", CSR_WR_COUNT, 64'd64);
        check_csr("write read run rd count", CSR_RD_COUNT, 64'd64);
        check_transfers("write read run", 12'h400, 64, 1'b1, 1'b1);

        // Second start while busy is dropped
        launch_run(MODE_WRITE, 12'h600, 12, 64'habc);
        expect_writes(12'h600, 12, 64'habc);
        check_csr("busy start status", CSR_STATUS, 64'd1);
        mmio_wr(CSR_CTRL, {61'd0, MODE_READ, 1'b1});
        wait_done("busy start");
        check_csr("busy start wr count", CSR_WR_COUNT, 64'd12);
        check_csr("busy start rd count", CSR_RD_COUNT, 64'd0);
        check_transfers("busy start", 12'h600, 12, 1'b1, 1'b0);

        // Empty runs
        launch_run(MODE_WRITE, 12'h700, 0, 64'd5);
        wait_done("zero length");
        check_csr("zero length wr count", CSR_WR_COUNT, 64'd0);
        check_csr("zero length rd count", CSR_RD_COUNT, 64'd0);
        check_transfers("zero length", 12'h700, 0, 1'b1, 1'b1);
        launch_run(MODE_IDLE, 12'h700, 16, 64'd5);
        wait_done("idle mode");
        check_csr("idle mode wr count", CSR_WR_COUNT, 64'd0);
        check_csr("idle mode rd count", CSR_RD_COUNT, 64'd0);
        check_csr("idle mode checksum", CSR_CHECKSUM, 64'd0);
        check_transfers("idle mode", 12'h700, 16, 1'b0, 1'b0);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- flist.f
afu_pkg.sv
afu_csr_decode.sv
afu_rdwr_engine.sv
afu_eng_status.sv
afu_top.sv
tb_clkgen.sv
tb_afu.sv

//--- Makefile
# Verilator build and run for the accelerator testbench

VERILATOR  ?= verilator
TOP        ?= tb_afu
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
FAIL_MSG   ?= \*\*\* FAILED \*\*\*
PASS_MSG   ?= \*\*\* PASSED \*\*\*

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The log decides the result; a missing pass line counts as a failure
run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '$(FAIL_MSG)' $(LOG) || ! grep -q '$(PASS_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
